//--- hdl/compressed_expander.sv
module compressed_expander (
  input  logic [id_pkg::ILEN-1:0] instr_i,
  output logic [id_pkg::ILEN-1:0] instr_o,
  output logic                    is_compressed_o,
  output logic                    illegal_o
);

  import id_pkg::*;

  logic [15:0] c_instr;
  logic [4:0]  c_rd_rs1;
  logic [4:0]  c_rs2;
  logic [4:0]  c_rd_p;
  logic [4:0]  c_rs1_p;

  assign c_instr  = instr_i[15:0];
  assign c_rd_rs1 = c_instr[11:7];
  assign c_rs2    = c_instr[6:2];
  // Primed register fields select x8 to x15
  assign c_rd_p   = {2'b01, c_instr[4:2]};
  assign c_rs1_p  = {2'b01, c_instr[9:7]};

  always_comb begin
    instr_o         = instr_i;
    is_compressed_o = (instr_i[1:0] != 2'b11);
    illegal_o       = 1'b0;

    if (is_compressed_o) begin
      illegal_o = 1'b1;
      unique case (c_instr[1:0])
        // --------------------
        // Quadrant 0
        // --------------------
        2'b00: begin
          if (c_instr[15:13] == 3'b010) begin
            // C.LW
            instr_o = {5'b0, c_instr[5], c_instr[12:10], c_instr[6], 2'b00,
                       c_rs1_p, 3'b010, c_rd_p, OPC_LOAD};
            illegal_o = 1'b0;
          end else if (c_instr[15:13] == 3'b110) begin
            // C.SW
            instr_o = {5'b0, c_instr[5], c_instr[12], c_rd_p, c_rs1_p, 3'b010,
                       c_instr[11:10], c_instr[6], 2'b00, OPC_STORE};
            illegal_o = 1'b0;
          end
        end
        // --------------------
        // Quadrant 1
        // --------------------
        2'b01: begin
          unique case (c_instr[15:13])
            3'b000: begin
              // C.ADDI
              instr_o = {{6{c_instr[12]}}, c_instr[12], c_instr[6:2], c_rd_rs1,
                         3'b000, c_rd_rs1, OPC_OP_IMM};
              illegal_o = 1'b0;
            end
            3'b010: begin
              // C.LI, an ADDI from x0
              instr_o = {{6{c_instr[12]}}, c_instr[12], c_instr[6:2], 5'b0,
                         3'b000, c_rd_rs1, OPC_OP_IMM};
              illegal_o = 1'b0;
            end
            3'b101: begin
              // C.J becomes JAL x0
              instr_o = {c_instr[12], c_instr[8], c_instr[10:9], c_instr[6],
                         c_instr[7], c_instr[2], c_instr[11], c_instr[5:3],
                         c_instr[12], {8{c_instr[12]}}, 5'b0, OPC_JAL};
              illegal_o = 1'b0;
            end
            3'b110, 3'b111: begin
              // C.BEQZ and C.BNEZ, funct3 bit 0 taken from bit 13
              instr_o = {c_instr[12], {3{c_instr[12]}}, c_instr[6:5], c_instr[2],
                         5'b0, c_rs1_p, 2'b00, c_instr[13], c_instr[11:10],
                         c_instr[4:3], c_instr[12], OPC_BRANCH};
              illegal_o = 1'b0;
            end
            default: begin
              illegal_o = 1'b1;
            end
          endcase
        end
        // --------------------
        // Quadrant 2
        // --------------------
        2'b10: begin
          if (c_instr[15:13] == 3'b100) begin
            if (!c_instr[12]) begin
              if (c_rs2 != 5'd0) begin
                // C.MV
                instr_o   = {7'b0, c_rs2, 5'b0, 3'b000, c_rd_rs1, OPC_OP};
                illegal_o = 1'b0;
              end else if (c_rd_rs1 != 5'd0) begin
                // C.JR, rs1 of x0 is reserved
                instr_o   = {12'b0, c_rd_rs1, 3'b000, 5'b0, OPC_JALR};
                illegal_o = 1'b0;
              end
            end else if (c_rs2 != 5'd0) begin
              // C.ADD; C.JALR and C.EBREAK are not supported
              instr_o   = {7'b0, c_rs2, c_rd_rs1, 3'b000, c_rd_rs1, OPC_OP};
              illegal_o = 1'b0;
            end
          end
        end
        default: begin
          illegal_o = 1'b1;
        end
      endcase

      // Unsupported words leave the expander as they came in
      if (illegal_o) begin
        instr_o = instr_i;
      end
    end
  end

endmodule

//--- hdl/id_pkg.sv
package id_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int unsigned XLEN       = 32;
  localparam int unsigned ILEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned FU_W       = 3;
  localparam int unsigned OP_W       = 4;

  // --------------------
  // Functional units
  // --------------------
  localparam logic [FU_W-1:0] FU_NONE   = 3'd0;
  localparam logic [FU_W-1:0] FU_ALU    = 3'd1;
  localparam logic [FU_W-1:0] FU_LOAD   = 3'd2;
  localparam logic [FU_W-1:0] FU_STORE  = 3'd3;
  localparam logic [FU_W-1:0] FU_BRANCH = 3'd4;
  localparam logic [FU_W-1:0] FU_JUMP   = 3'd5;

  // --------------------
  // Major opcodes
  // --------------------
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // Format views of one 32-bit instruction word
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_type;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_type;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s_type;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b_type;
  } instr_u;

endpackage

//--- hdl/id_stage.sv
module id_stage (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  input  logic                          fetch_valid_i,
  input  logic [id_pkg::ILEN-1:0]       fetch_instr_i,
  input  logic [id_pkg::XLEN-1:0]       fetch_pc_i,
  output logic                          fetch_ready_o,
  output logic                          issue_valid_o,
  input  logic                          issue_ack_i,
  output logic [id_pkg::FU_W-1:0]       fu_o,
  output logic [id_pkg::OP_W-1:0]       op_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [id_pkg::XLEN-1:0]       imm_o,
  output logic                          use_imm_o,
  output logic                          illegal_o,
  output logic                          is_ctrl_flow_o,
  output logic                          is_compressed_o,
  output logic [id_pkg::ILEN-1:0]       orig_instr_o,
  output logic [id_pkg::XLEN-1:0]       pc_o
);

  import id_pkg::*;

  logic [ILEN-1:0]       exp_instr;
  logic                  exp_is_compressed;
  logic                  exp_illegal;
  logic [FU_W-1:0]       dec_fu;
  logic [OP_W-1:0]       dec_op;
  logic [REG_ADDR_W-1:0] dec_rs1;
  logic [REG_ADDR_W-1:0] dec_rs2;
  logic [REG_ADDR_W-1:0] dec_rd;
  logic [XLEN-1:0]       dec_imm;
  logic                  dec_use_imm;
  logic                  dec_illegal;
  logic                  dec_is_ctrl_flow;

  compressed_expander u_expander (
    .instr_i        (fetch_instr_i),
    .instr_o        (exp_instr),
    .is_compressed_o(exp_is_compressed),
    .illegal_o      (exp_illegal)
  );

  instr_decoder u_decoder (
    .instr_i        (exp_instr),
    .illegal_c_i    (exp_illegal),
    .is_compressed_i(exp_is_compressed),
    .fu_o           (dec_fu),
    .op_o           (dec_op),
    .rs1_o          (dec_rs1),
    .rs2_o          (dec_rs2),
    .rd_o           (dec_rd),
    .imm_o          (dec_imm),
    .use_imm_o      (dec_use_imm),
    .illegal_o      (dec_illegal),
    .is_ctrl_flow_o (dec_is_ctrl_flow)
  );

  // The issue side sees the fetch word before expansion
  issue_register u_issue_reg (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_pc_i     (fetch_pc_i),
    .orig_instr_i   (fetch_instr_i),
    .fu_i           (dec_fu),
    .op_i           (dec_op),
    .rs1_i          (dec_rs1),
    .rs2_i          (dec_rs2),
    .rd_i           (dec_rd),
    .imm_i          (dec_imm),
    .use_imm_i      (dec_use_imm),
    .illegal_i      (dec_illegal),
    .is_ctrl_flow_i (dec_is_ctrl_flow),
    .is_compressed_i(exp_is_compressed),
    .issue_ack_i    (issue_ack_i),
    .fetch_ready_o  (fetch_ready_o),
    .issue_valid_o  (issue_valid_o),
    .fu_o           (fu_o),
    .op_o           (op_o),
    .rs1_o          (rs1_o),
    .rs2_o          (rs2_o),
    .rd_o           (rd_o),
    .imm_o          (imm_o),
    .use_imm_o      (use_imm_o),
    .illegal_o      (illegal_o),
    .is_ctrl_flow_o (is_ctrl_flow_o),
    .is_compressed_o(is_compressed_o),
    .orig_instr_o   (orig_instr_o),
    .pc_o           (pc_o)
  );

endmodule

//--- hdl/instr_decoder.sv
module instr_decoder (
  input  logic [id_pkg::ILEN-1:0]       instr_i,
  input  logic                          illegal_c_i,
  input  logic                          is_compressed_i,
  output logic [id_pkg::FU_W-1:0]       fu_o,
  output logic [id_pkg::OP_W-1:0]       op_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [id_pkg::XLEN-1:0]       imm_o,
  output logic                          use_imm_o,
  output logic                          illegal_o,
  output logic                          is_ctrl_flow_o
);

  import id_pkg::*;

  instr_u          instr;
  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_s_type;
  logic [XLEN-1:0] imm_b_type;
  logic [XLEN-1:0] imm_j_type;
  logic [XLEN-1:0] imm_u_type;
  logic            illegal_32;

  assign instr = instr_i;

  // --------------------
  // Immediates
  // --------------------
  assign imm_i_type = {{20{instr.i_type.imm[11]}}, instr.i_type.imm};
  assign imm_s_type = {{20{instr.s_type.imm_hi[6]}}, instr.s_type.imm_hi, instr.s_type.imm_lo};
  assign imm_b_type = {{19{instr.b_type.imm12}}, instr.b_type.imm12, instr.b_type.imm11,
                       instr.b_type.imm10_5, instr.b_type.imm4_1, 1'b0};
  assign imm_j_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  // --------------------
  // Opcode decode
  // --------------------
  always_comb begin
    fu_o           = FU_NONE;
    op_o           = '0;
    rs1_o          = '0;
    rs2_o          = '0;
    rd_o           = '0;
    imm_o          = '0;
    use_imm_o      = 1'b0;
    is_ctrl_flow_o = 1'b0;
    illegal_32     = 1'b0;

    unique case (instr.r_type.opcode)
      OPC_OP: begin
        fu_o  = FU_ALU;
        rs1_o = instr.r_type.rs1;
        rs2_o = instr.r_type.rs2;
        rd_o  = instr.r_type.rd;
        op_o  = {instr.r_type.funct7[5], instr.r_type.funct3};
        // Alternate funct7 is only defined for SUB and SRA
        if (instr.r_type.funct7 == 7'b0100000) begin
          illegal_32 = !(instr.r_type.funct3 inside {3'b000, 3'b101});
        end else begin
          illegal_32 = (instr.r_type.funct7 != 7'b0000000);
        end
      end
      OPC_OP_IMM: begin
        fu_o      = FU_ALU;
        rs1_o     = instr.i_type.rs1;
        rd_o      = instr.i_type.rd;
        imm_o     = imm_i_type;
        use_imm_o = 1'b1;
        // SRAI shares the SRA operation code
        op_o      = {(instr.i_type.funct3 == 3'b101) && instr_i[30], instr.i_type.funct3};
      end
      OPC_LOAD: begin
        fu_o       = FU_LOAD;
        rs1_o      = instr.i_type.rs1;
        rd_o       = instr.i_type.rd;
        imm_o      = imm_i_type;
        use_imm_o  = 1'b1;
        illegal_32 = (instr.i_type.funct3 != 3'b010);
      end
      OPC_STORE: begin
        fu_o       = FU_STORE;
        rs1_o      = instr.s_type.rs1;
        rs2_o      = instr.s_type.rs2;
        imm_o      = imm_s_type;
        use_imm_o  = 1'b1;
        illegal_32 = (instr.s_type.funct3 != 3'b010);
      end
      OPC_BRANCH: begin
        fu_o           = FU_BRANCH;
        rs1_o          = instr.b_type.rs1;
        rs2_o          = instr.b_type.rs2;
        imm_o          = imm_b_type;
        op_o           = {1'b0, instr.b_type.funct3};
        is_ctrl_flow_o = 1'b1;
        illegal_32     = instr.b_type.funct3 inside {3'b010, 3'b011};
      end
      OPC_JAL: begin
        fu_o           = FU_JUMP;
        rd_o           = instr.r_type.rd;
        imm_o          = imm_j_type;
        use_imm_o      = 1'b1;
        is_ctrl_flow_o = 1'b1;
      end
      OPC_JALR: begin
        fu_o           = FU_JUMP;
        rs1_o          = instr.i_type.rs1;
        rd_o           = instr.i_type.rd;
        imm_o          = imm_i_type;
        use_imm_o      = 1'b1;
        is_ctrl_flow_o = 1'b1;
      end
      OPC_LUI: begin
        fu_o      = FU_ALU;
        rd_o      = instr.r_type.rd;
        imm_o     = imm_u_type;
        use_imm_o = 1'b1;
      end
      default: begin
        illegal_32 = 1'b1;
      end
    endcase

    // The expander flag only has meaning for a compressed word
    illegal_o = illegal_32 || (illegal_c_i && is_compressed_i);
    if (illegal_o) begin
      fu_o           = FU_NONE;
      is_ctrl_flow_o = 1'b0;
    end
  end

endmodule

//--- hdl/issue_register.sv
module issue_register (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  input  logic                          fetch_valid_i,
  input  logic [id_pkg::XLEN-1:0]       fetch_pc_i,
  input  logic [id_pkg::ILEN-1:0]       orig_instr_i,
  input  logic [id_pkg::FU_W-1:0]       fu_i,
  input  logic [id_pkg::OP_W-1:0]       op_i,
  input  logic [id_pkg::REG_ADDR_W-1:0] rs1_i,
  input  logic [id_pkg::REG_ADDR_W-1:0] rs2_i,
  input  logic [id_pkg::REG_ADDR_W-1:0] rd_i,
  input  logic [id_pkg::XLEN-1:0]       imm_i,
  input  logic                          use_imm_i,
  input  logic                          illegal_i,
  input  logic                          is_ctrl_flow_i,
  input  logic                          is_compressed_i,
  input  logic                          issue_ack_i,
  output logic                          fetch_ready_o,
  output logic                          issue_valid_o,
  output logic [id_pkg::FU_W-1:0]       fu_o,
  output logic [id_pkg::OP_W-1:0]       op_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [id_pkg::XLEN-1:0]       imm_o,
  output logic                          use_imm_o,
  output logic                          illegal_o,
  output logic                          is_ctrl_flow_o,
  output logic                          is_compressed_o,
  output logic [id_pkg::ILEN-1:0]       orig_instr_o,
  output logic [id_pkg::XLEN-1:0]       pc_o
);

  import id_pkg::*;

  logic valid_q;
  logic valid_d;
  logic transfer;

  // Space frees up in the same cycle the issue side takes the entry
  assign fetch_ready_o = !valid_q || issue_ack_i;
  assign transfer      = fetch_valid_i && fetch_ready_o;
  assign issue_valid_o = valid_q;

  always_comb begin
    valid_d = valid_q;
    if (issue_ack_i) begin
      valid_d = 1'b0;
    end
    if (transfer) begin
      valid_d = 1'b1;
    end
    // Flush wins, a fetch taken in this cycle is dropped
    if (flush_i) begin
      valid_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_d;
    end
  end

  // --------------------
  // Entry payload
  // --------------------
  always_ff @(posedge clk_i) begin
    if (transfer) begin
      fu_o            <= fu_i;
      op_o            <= op_i;
      rs1_o           <= rs1_i;
      rs2_o           <= rs2_i;
      rd_o            <= rd_i;
      imm_o           <= imm_i;
      use_imm_o       <= use_imm_i;
      illegal_o       <= illegal_i;
      is_ctrl_flow_o  <= is_ctrl_flow_i;
      is_compressed_o <= is_compressed_i;
      orig_instr_o    <= orig_instr_i;
      pc_o            <= fetch_pc_i;
    end
  end

endmodule

//--- verification/id_ref_model.svh
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// Expected expansion, returned as {illegal, is_compressed, instr}
function automatic logic [33:0] expand_ref(input logic [31:0] w);
  logic [15:0] c;
  logic [11:0] imm;
  logic [20:0] j;
  logic [12:0] b;
  logic [31:0] res;
  logic        ill;
  c   = w[15:0];
  res = w;
  ill = 1'b1;
  if (w[1:0] == 2'b11) begin
    return {2'b00, w};
  end
  case ({c[15:13], c[1:0]})
    5'b010_00: begin
      imm = {5'b0, c[5], c[12:10], c[6], 2'b00};
      res = {imm, 2'b01, c[9:7], 3'b010, 2'b01, c[4:2], OPC_LOAD};
      ill = 1'b0;
    end
    5'b110_00: begin
      imm = {5'b0, c[5], c[12:10], c[6], 2'b00};
      res = {imm[11:5], 2'b01, c[4:2], 2'b01, c[9:7], 3'b010, imm[4:0], OPC_STORE};
      ill = 1'b0;
    end
    5'b000_01, 5'b010_01: begin
      imm = {{6{c[12]}}, c[12], c[6:2]};
      res = {imm, (c[14] ? 5'd0 : c[11:7]), 3'b000, c[11:7], OPC_OP_IMM};
      ill = 1'b0;
    end
    5'b101_01: begin
      j   = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
      res = {j[20], j[10:1], j[11], j[19:12], 5'd0, OPC_JAL};
      ill = 1'b0;
    end
    5'b110_01, 5'b111_01: begin
      b   = {{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
      res = {b[12], b[10:5], 5'd0, 2'b01, c[9:7], 2'b00, c[13], b[4:1], b[11], OPC_BRANCH};
      ill = 1'b0;
    end
    5'b100_10: begin
      if (!c[12] && c[6:2] != 5'd0) begin
        res = {7'b0, c[6:2], 5'd0, 3'b000, c[11:7], OPC_OP};
        ill = 1'b0;
      end else if (!c[12] && c[11:7] != 5'd0) begin
        res = {12'b0, c[11:7], 3'b000, 5'd0, OPC_JALR};
        ill = 1'b0;
      end else if (c[12] && c[6:2] != 5'd0) begin
        res = {7'b0, c[6:2], c[11:7], 3'b000, c[11:7], OPC_OP};
        ill = 1'b0;
      end
    end
    default: ill = 1'b1;
  endcase
  return {ill, 1'b1, (ill ? w : res)};
endfunction

// Expected decode of an expanded word
function automatic void decode_ref(input logic [31:0] w, input logic ill_c,
                                   output logic [2:0] fu, output logic [3:0] op,
                                   output logic [4:0] rs1, output logic [4:0] rs2,
                                   output logic [4:0] rd, output logic [31:0] imm,
                                   output logic use_imm, output logic ill,
                                   output logic ctrl);
  instr_u u;
  u       = w;
  fu      = FU_NONE;
  op      = 4'd0;
  rs1     = 5'd0;
  rs2     = 5'd0;
  rd      = 5'd0;
  imm     = 32'd0;
  use_imm = 1'b0;
  ctrl    = 1'b0;
  ill     = 1'b0;
  case (u.r_type.opcode)
    OPC_OP: begin
      fu  = FU_ALU;
      rs1 = u.r_type.rs1;
      rs2 = u.r_type.rs2;
      rd  = u.r_type.rd;
      op  = {u.r_type.funct7 == 7'b0100000, u.r_type.funct3};
      ill = !(u.r_type.funct7 == 7'b0000000 || (u.r_type.funct7 == 7'b0100000 &&
              (u.r_type.funct3 == 3'b000 || u.r_type.funct3 == 3'b101)));
    end
    OPC_OP_IMM, OPC_LOAD, OPC_JALR: begin
      fu      = (u.i_type.opcode == OPC_OP_IMM) ? FU_ALU :
                (u.i_type.opcode == OPC_LOAD) ? FU_LOAD : FU_JUMP;
      rs1     = u.i_type.rs1;
      rd      = u.i_type.rd;
      imm     = {{20{u.i_type.imm[11]}}, u.i_type.imm};
      use_imm = 1'b1;
      ctrl    = (fu == FU_JUMP);
      if (fu == FU_ALU) begin
        op = {u.i_type.funct3 == 3'b101 && u.i_type.imm[10], u.i_type.funct3};
      end
      ill = (fu == FU_LOAD) && (u.i_type.funct3 != 3'b010);
    end
    OPC_STORE: begin
      fu      = FU_STORE;
      rs1     = u.s_type.rs1;
      rs2     = u.s_type.rs2;
      imm     = {{20{w[31]}}, u.s_type.imm_hi, u.s_type.imm_lo};
      use_imm = 1'b1;
      ill     = (u.s_type.funct3 != 3'b010);
    end
    OPC_BRANCH: begin
      fu   = FU_BRANCH;
      rs1  = u.b_type.rs1;
      rs2  = u.b_type.rs2;
      imm  = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      op   = {1'b0, u.b_type.funct3};
      ctrl = 1'b1;
      ill  = (u.b_type.funct3[2:1] == 2'b01);
    end
    OPC_JAL: begin
      fu      = FU_JUMP;
      rd      = u.r_type.rd;
      imm     = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      use_imm = 1'b1;
      ctrl    = 1'b1;
    end
    OPC_LUI: begin
      fu      = FU_ALU;
      rd      = u.r_type.rd;
      imm     = {w[31:12], 12'd0};
      use_imm = 1'b1;
    end
    default: ill = 1'b1;
  endcase
  ill = ill || ill_c;
  if (ill) begin
    fu   = FU_NONE;
    ctrl = 1'b0;
  end
endfunction

`endif

//--- verification/id_stage_tb.sv
module id_stage_tb;

  import id_pkg::*;

  `include "id_ref_model.svh"

  localparam int TIMEOUT_CYCLES = 2000;

  logic        clk_i;
  logic        rst_ni;
  logic        flush_i;
  logic        fetch_valid_i;
  logic [31:0] fetch_instr_i;
  logic [31:0] fetch_pc_i;
  logic        fetch_ready_o;
  logic        issue_valid_o;
  logic        issue_ack_i;
  logic [2:0]  fu_o;
  logic [3:0]  op_o;
  logic [4:0]  rs1_o;
  logic [4:0]  rs2_o;
  logic [4:0]  rd_o;
  logic [31:0] imm_o;
  logic        use_imm_o;
  logic        illegal_o;
  logic        is_ctrl_flow_o;
  logic        is_compressed_o;
  logic [31:0] orig_instr_o;
  logic [31:0] pc_o;

  integer      seed = 32'h6ba8;
  int          errors;
  int          checks;
  int          accepted;
  int          issued;
  int          cycle;
  int          ack_mode;
  logic [31:0] word_q[$];
  logic [31:0] pc_q[$];
  logic        hold_q;
  logic [31:0] held_word;
  logic [31:0] held_pc;
  logic [31:0] held_imm;

  id_stage u_dut (
    .clk_i(clk_i), .rst_ni(rst_ni), .flush_i(flush_i),
    .fetch_valid_i(fetch_valid_i), .fetch_instr_i(fetch_instr_i),
    .fetch_pc_i(fetch_pc_i), .fetch_ready_o(fetch_ready_o),
    .issue_valid_o(issue_valid_o), .issue_ack_i(issue_ack_i),
    .fu_o(fu_o), .op_o(op_o), .rs1_o(rs1_o), .rs2_o(rs2_o), .rd_o(rd_o),
    .imm_o(imm_o), .use_imm_o(use_imm_o), .illegal_o(illegal_o),
    .is_ctrl_flow_o(is_ctrl_flow_o), .is_compressed_o(is_compressed_o),
    .orig_instr_o(orig_instr_o), .pc_o(pc_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      $display("ERROR %s expected %h got %h", name, exp, act);
      errors++;
    end
  endtask

  // --------------------
  // Issue side
  // --------------------
  always @(negedge clk_i) begin
    if (ack_mode == 0) begin
      issue_ack_i <= 1'b1;
    end else if (ack_mode == 1) begin
      issue_ack_i <= (($random(seed) & 3) == 0);
    end else begin
      issue_ack_i <= 1'b0;
    end
  end

  always @(posedge clk_i) begin
    cycle++;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  // Compare each acknowledged entry with the oldest accepted fetch
  always @(posedge clk_i) begin : scoreboard
    logic [33:0] x;
    logic [31:0] w;
    logic [31:0] pc;
    logic [2:0]  e_fu;
    logic [3:0]  e_op;
    logic [4:0]  e_rs1;
    logic [4:0]  e_rs2;
    logic [4:0]  e_rd;
    logic [31:0] e_imm;
    logic        e_use;
    logic        e_ill;
    logic        e_ctrl;
    if (rst_ni) begin
      if (issue_valid_o && issue_ack_i) begin
        issued++;
        assert (word_q.size() != 0) else begin
          $display("An entry was issued with no fetch left to match it");
          errors++;
        end
        if (word_q.size() != 0) begin
          w  = word_q.pop_front();
          pc = pc_q.pop_front();
          x  = expand_ref(w);
          decode_ref(x[31:0], x[33], e_fu, e_op, e_rs1, e_rs2, e_rd, e_imm, e_use, e_ill, e_ctrl);
          check_val("orig_instr_o", w, orig_instr_o);
          check_val("pc_o", pc, pc_o);
          check_val("is_compressed_o", x[32], is_compressed_o);
          check_val("fu_o", e_fu, fu_o);
          check_val("illegal_o", e_ill, illegal_o);
          check_val("is_ctrl_flow_o", e_ctrl, is_ctrl_flow_o);
          if (!e_ill) begin
            check_val("op_o", e_op, op_o);
            check_val("rs1_o", e_rs1, rs1_o);
            check_val("rs2_o", e_rs2, rs2_o);
            check_val("rd_o", e_rd, rd_o);
            check_val("imm_o", e_imm, imm_o);
            check_val("use_imm_o", e_use, use_imm_o);
          end
        end
      end else if (issue_valid_o && flush_i && word_q.size() != 0) begin
        void'(word_q.pop_front());
        void'(pc_q.pop_front());
      end
      // Held entry must not move while the issue side stalls
      if (hold_q && issue_valid_o) begin
        check_val("orig_instr_o", held_word, orig_instr_o);
        check_val("pc_o", held_pc, pc_o);
        check_val("imm_o", held_imm, imm_o);
      end
      if (issue_valid_o && !issue_ack_i) begin
        check_val("fetch_ready_o", 32'd0, fetch_ready_o);
      end
      hold_q    = issue_valid_o && !issue_ack_i && !flush_i;
      held_word = orig_instr_o;
      held_pc   = pc_o;
      held_imm  = imm_o;
      if (fetch_valid_i && fetch_ready_o && !flush_i) begin
        word_q.push_back(fetch_instr_i);
        pc_q.push_back(fetch_pc_i);
        accepted++;
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  task automatic send(input logic [31:0] w);
    int n;
    n             = accepted;
    fetch_valid_i = 1'b1;
    fetch_instr_i = w;
    fetch_pc_i    = $random(seed) & 32'hffff_fffe;
    do @(negedge clk_i); while (accepted == n);
  endtask

  task automatic drain();
    fetch_valid_i = 1'b0;
    while (word_q.size() != 0 || issue_valid_o) @(negedge clk_i);
  endtask

  task automatic report(input string name, input int err_start);
    $display("Test %s finished with %0d errors", name, errors - err_start);
  endtask

  function automatic logic [31:0] rand_rv32i();
    logic [31:0] w;
    logic [2:0]  f3;
    w  = $random(seed);
    f3 = w[14:12];
    case ($unsigned($random(seed)) % 8)
      0: begin
        w[31:25] = (w[31] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0;
        w[6:0]   = OPC_OP;
      end
      1: begin
        if (f3 == 3'b001 || f3 == 3'b101) w[31:25] = {1'b0, w[30] && f3[2], 5'b0};
        w[6:0] = OPC_OP_IMM;
      end
      2: w = {w[31:15], 3'b010, w[11:7], OPC_LOAD};
      3: w = {w[31:15], 3'b010, w[11:7], OPC_STORE};
      4: w = {w[31:15], (f3[2:1] == 2'b01) ? 3'b000 : f3, w[11:7], OPC_BRANCH};
      5: w[6:0] = OPC_JAL;
      6: w = {w[31:15], 3'b000, w[11:7], OPC_JALR};
      default: w[6:0] = OPC_LUI;
    endcase
    return w;
  endfunction

  function automatic logic [31:0] rand_rvc(input int form);
    logic [31:0] w;
    w = $random(seed);
    case (form)
      0: w[15:0] = {3'b010, w[12:2], 2'b00};
      1: w[15:0] = {3'b110, w[12:2], 2'b00};
      2: w[15:0] = {3'b000, w[12:2], 2'b01};
      3: w[15:0] = {3'b010, w[12:2], 2'b01};
      4: w[15:0] = {3'b101, w[12:2], 2'b01};
      5: w[15:0] = {3'b110, w[12:2], 2'b01};
      6: w[15:0] = {3'b111, w[12:2], 2'b01};
      7: w[15:0] = {4'b1000, w[11:7], w[6:3], 1'b1, 2'b10};
      8: w[15:0] = {4'b1001, w[11:7], w[6:3], 1'b1, 2'b10};
      default: w[15:0] = {4'b1000, w[11:8], 1'b1, 5'd0, 2'b10};
    endcase
    return w;
  endfunction

  initial begin : main
    int e0;
    int start;
    rst_ni = 1'b0;
    flush_i = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_instr_i = '0;
    fetch_pc_i = '0;
    issue_ack_i = 1'b0;
    ack_mode = 2;
    hold_q = 1'b0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    e0 = errors;
    check_val("issue_valid_o", 32'd0, issue_valid_o);
    check_val("fetch_ready_o", 32'd1, fetch_ready_o);
    report("reset", e0);

    e0 = errors;
    ack_mode = 0;
    start = cycle;
    for (int i = 0; i < 200; i++) send(rand_rv32i());
    assert (cycle - start == 200) else begin
      $display("Random RV32I words took %0d cycles instead of 200", cycle - start);
      errors++;
    end
    drain();
    report("random_rv32i", e0);

    e0 = errors;
    for (int i = 0; i < 100; i++) send(rand_rvc(i % 10));
    drain();
    report("compressed", e0);

    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      send($random(seed) & 32'hffff_0000);
      send($random(seed) & 32'h0000_1ffc);
      send(({16'h0, 16'h2001} | ($random(seed) & 32'h1ffc)));
      send(({16'h0, 16'h1002} | ($random(seed) & 32'h007c)));
      send(32'h0000_8002);
      send(($random(seed) & 32'hffff_ff80) | 32'h73);
      send(($random(seed) & 32'hffff_8f80) | {25'd0, OPC_LOAD});
      send(($random(seed) & 32'hffff_8f80) | 32'h2000 | {25'd0, OPC_BRANCH});
      send(($random(seed) & 32'h01ff_ff80) | 32'h0200_0000 | {25'd0, OPC_OP});
    end
    drain();
    report("illegal", e0);

    e0 = errors;
    ack_mode = 1;
    for (int i = 0; i < 40; i++) send(rand_rv32i());
    drain();
    check_val("issued entries", 32'd376, issued);
    report("backpressure", e0);

    e0 = errors;
    ack_mode = 2;
    send(rand_rv32i());
    fetch_valid_i = 1'b0;
    @(negedge clk_i);
    flush_i = 1'b1;
    fetch_valid_i = 1'b1;
    fetch_instr_i = 32'h0000_0013;
    @(negedge clk_i);
    flush_i = 1'b0;
    fetch_valid_i = 1'b0;
    check_val("issue_valid_o", 32'd0, issue_valid_o);
    flush_i = 1'b1;
    fetch_valid_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    fetch_valid_i = 1'b0;
    check_val("issue_valid_o", 32'd0, issue_valid_o);
    check_val("pending entries", 32'd0, word_q.size());
    ack_mode = 0;
    send(rand_rv32i());
    drain();
    check_val("issued entries", 32'd377, issued);
    report("flush", e0);

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+verification
hdl/id_pkg.sv
hdl/compressed_expander.sv
hdl/instr_decoder.sv
hdl/issue_register.sv
hdl/id_stage.sv
verification/id_stage_tb.sv
